/* Makefile */
# Verilator simulation of the opc16_core testbench, run from the project root
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module tb_opc16_core -f opc16_core.f
	./obj_dir/Vtb_opc16_core | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/acc_file.sv */
//------------------------------
// Accumulators A to D
// One combinational read, one write
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module acc_file import cpu_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire word_t result,
	output word_t acc_rd,
	dp_ctrl_if.acc ctrl
);

	word_t acc [4]; // Indexed by acc_sel_t

	assign acc_rd = acc[ctrl.rd_sel];

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			acc <= '{default: '0};
		else if (ctrl.wr_en)
			acc[ctrl.wr_sel] <= result;
	end

endmodule

`default_nettype wire

/* design/addr_gen.sv */
//------------------------------
// Program counter and address bus
// Operand address is {di, result}, high word from di
// A stalled PC repeats the last address
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module addr_gen import cpu_pkg::*; #(
	parameter addr_t reset_pc = '0
) (
	input wire logic clk,
	input wire logic reset,
	input wire word_t di,
	input wire word_t result,
	output addr_t ab,
	dp_ctrl_if.addr ctrl
);

	addr_t pc; // Next word to fetch
	addr_t ab_hold; // Address of the previous cycle
	addr_t oper;
	addr_t pc_base;

	assign oper = {di, result};
	assign pc_base = ctrl.pc_load ? oper : pc;

	always_comb begin
		if (ctrl.ab_sel == AB_OPER)
			ab = oper;
		else if (ctrl.pc_inc)
			ab = pc;
		else
			ab = ab_hold; // REG refetches the opcode seen in DECODE
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= reset_pc;
		else
			pc <= pc_base + addr_t'(ctrl.pc_inc);
	end

	always_ff @(posedge clk) begin
		ab_hold <= ab;
	end

endmodule

`default_nettype wire

/* design/alu.sv */
//------------------------------
// Adder and logic unit with carry flag
// Result and carry out are registered every cycle
// Carry out is zero for logic operations
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire word_t di,
	input wire word_t acc_rd,
	output word_t result,
	dp_ctrl_if.alu ctrl
);

	word_t ai, bi, alu_out;
	logic ci, co, co_q, carry;
	logic [WORD_W:0] sum; // Extra bit for carry out

	always_comb begin
		ai = (ctrl.ai_sel == AI_ACC) ? acc_rd : '0;
		bi = (ctrl.bi_sel == BI_DI) ? di : '0;
		if (ctrl.alu_op == ALU_SUB)
			bi = ~bi; // A + ~B + C, borrow is inverted carry
		case (ctrl.ci_sel)
			CI_FLAG: ci = carry;
			CI_ONE: ci = 1'b1;
			default: ci = 1'b0;
		endcase
		sum = {1'b0, ai} + {1'b0, bi} + {{WORD_W{1'b0}}, ci};
		co = 1'b0;
		case (ctrl.alu_op)
			ALU_OR: alu_out = ai | bi;
			ALU_AND: alu_out = ai & bi;
			ALU_EOR: alu_out = ai ^ bi;
			ALU_ADD, ALU_SUB: begin
				alu_out = sum[WORD_W-1:0];
				co = sum[WORD_W];
			end
			default: alu_out = ai; // PASS_A
		endcase
	end

	always_ff @(posedge clk) begin
		result <= alu_out;
		co_q <= co;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			carry <= 1'b0;
		else case (ctrl.carry_op)
			C_ALU: carry <= co_q; // Carry of last cycle's operation
			C_CLEAR: carry <= 1'b0;
			C_SET: carry <= 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
//------------------------------
// Shared types for the 16-bit accumulator core
// Data width is fixed at 16 by the opcode layout
// Only the carry flag is kept, no N, Z or V
//------------------------------
`default_nettype none

package cpu_pkg;

	localparam int WORD_W = 16; // Data bus and opcode width
	localparam int ADDR_W = 32; // Two words of address

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t; // Upper word is the high half

	typedef enum logic [1:0] {ACC_A, ACC_B, ACC_C, ACC_D} acc_sel_t;

	// OR, AND and EOR follow the aaa field order of the opcode
	typedef enum logic [2:0] {ALU_OR, ALU_AND, ALU_EOR, ALU_ADD, ALU_SUB, ALU_PASS_A} alu_op_t;

	typedef enum logic [2:0] {FETCH, DECODE, REG, ABS0, ABS1, JMP0, JMP1} state_t;

	typedef enum logic {AI_ACC, AI_ZERO} ai_sel_t;
	typedef enum logic {BI_DI, BI_ZERO} bi_sel_t;
	typedef enum logic [1:0] {CI_FLAG, CI_ONE, CI_ZERO} ci_sel_t;
	typedef enum logic [1:0] {C_HOLD, C_ALU, C_CLEAR, C_SET} carry_op_t;
	typedef enum logic {AB_PC, AB_OPER} ab_sel_t; // Operand is {di, result}

	typedef struct packed {
		logic [5:0] zero; // Must be zero for a valid opcode
		acc_sel_t acc; // Bits 9..8
		logic [7:0] op; // Classic 6502 opcode
	} instr_raw_t;

	typedef struct packed {
		logic [5:0] zero;
		acc_sel_t acc;
		logic [2:0] aaa; // Operation group
		logic [2:0] bbb; // Addressing column
		logic [1:0] cc;
	} instr_fld_t;

	typedef union packed {
		instr_raw_t raw; // Exact opcode matches
		instr_fld_t fld; // Group and column decode
	} instr_t;

endpackage

`default_nettype wire

/* design/dp_ctrl_if.sv */
//------------------------------
// Per-cycle datapath selects
// Driven only by the sequencer
//------------------------------
`timescale 1ns/1ps
`default_nettype none

interface dp_ctrl_if import cpu_pkg::*; ();

	ai_sel_t ai_sel; // ALU A input
	bi_sel_t bi_sel; // ALU B input
	ci_sel_t ci_sel; // ALU carry in
	alu_op_t alu_op;
	carry_op_t carry_op; // Carry flag action
	acc_sel_t rd_sel; // Accumulator read port
	acc_sel_t wr_sel; // Accumulator write port
	logic wr_en;
	ab_sel_t ab_sel; // Address bus source
	logic pc_load; // PC takes the operand address
	logic pc_inc; // PC advances by one

	modport seq (
		output ai_sel, bi_sel, ci_sel, alu_op, carry_op,
		output rd_sel, wr_sel, wr_en,
		output ab_sel, pc_load, pc_inc
	);
	modport alu (input ai_sel, bi_sel, ci_sel, alu_op, carry_op);
	modport acc (input rd_sel, wr_sel, wr_en);
	modport addr (input ab_sel, pc_load, pc_inc);

endinterface

`default_nettype wire

/* design/opc16_core.sv */
//------------------------------
// Reduced 65Org16-style core, accumulators A to D
// Memory must be synchronous, data on di one cycle after ab
// No ready input, no interrupts, no stack
// A write is a cycle with we high, to ab, with dout
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module opc16_core import cpu_pkg::*; #(
	parameter addr_t reset_pc = '0 // First fetch address
) (
	input wire logic clk,
	input wire logic reset,
	output addr_t ab,
	input wire word_t di,
	output word_t dout,
	output logic we
);

	word_t result; // Registered ALU output
	word_t acc_rd; // Selected accumulator

	dp_ctrl_if ctrl ();

	sequencer i_sequencer (
		.clk(clk),
		.reset(reset),
		.di(di),
		.we(we),
		.ctrl(ctrl.seq)
	);

	alu i_alu (
		.clk(clk),
		.reset(reset),
		.di(di),
		.acc_rd(acc_rd),
		.result(result),
		.ctrl(ctrl.alu)
	);

	acc_file i_acc_file (
		.clk(clk),
		.reset(reset),
		.result(result),
		.acc_rd(acc_rd),
		.ctrl(ctrl.acc)
	);

	addr_gen #(.reset_pc(reset_pc)) i_addr_gen (
		.clk(clk),
		.reset(reset),
		.di(di),
		.result(result),
		.ab(ab),
		.ctrl(ctrl.addr)
	);

	assign dout = acc_rd; // Store data is the read port

endmodule

`default_nettype wire

/* design/sequencer.sv */
//------------------------------
// Opcode decode and state machine
// Bits 15..10 must be zero, else the word is a no-op
// STA immediate (89) is treated as a no-op
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module sequencer import cpu_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire word_t di,
	output logic we,
	dp_ctrl_if.seq ctrl
);

	localparam logic [7:0] OP_JMP = 8'h4c; // JMP abs
	localparam logic [7:0] OP_CLC = 8'h18;
	localparam logic [7:0] OP_SEC = 8'h38;
	localparam logic [2:0] AAA_STA = 3'b100;
	localparam logic [2:0] AAA_LDA = 3'b101;
	localparam logic [2:0] AAA_CMP = 3'b110;

	state_t state, next_state;
	instr_t ir; // di seen as an opcode
	logic valid, is_imm, is_abs, is_alu, is_xfer, is_jmp;
	logic load_reg, load_only, store, adc_sbc, compare, clc, sec;
	acc_sel_t src, dst;
	alu_op_t op, dec_op;

	assign ir = di;
	assign valid = (ir.raw.zero == '0);
	assign is_jmp = valid && {ir.raw.acc, ir.raw.op} == {ACC_A, OP_JMP};
	assign is_imm = valid && ir.fld.cc == 2'b01 && ir.fld.bbb == 3'b010 && ir.fld.aaa != AAA_STA;
	assign is_abs = valid && ir.fld.cc == 2'b01 && ir.fld.bbb == 3'b011; // Column D
	assign is_alu = is_imm || is_abs;
	assign is_xfer = valid && ir.fld.aaa[2:1] == 2'b10 && ir.fld.bbb[1:0] == 2'b10
		&& ir.fld.cc == 2'b11; // 8B, 9B, AB, BB

	always_comb begin
		case (ir.fld.aaa)
			3'b000, 3'b001, 3'b010: dec_op = alu_op_t'(ir.fld.aaa); // ORA, AND, EOR
			AAA_CMP, 3'b111: dec_op = ALU_SUB; // CMP, SBC
			default: dec_op = ALU_ADD; // ADC, LDA, STA
		endcase
		if (!is_alu)
			dec_op = ALU_PASS_A; // Transfers and no-ops
	end

	always_comb begin
		case (state)
			FETCH, REG, JMP1: next_state = DECODE;
			ABS0: next_state = ABS1;
			ABS1: next_state = FETCH;
			JMP0: next_state = JMP1;
			DECODE: begin
				if (is_jmp)
					next_state = JMP0;
				else if (is_imm)
					next_state = FETCH;
				else if (is_abs)
					next_state = ABS0;
				else
					next_state = REG; // CLC, SEC, transfers, no-ops
			end
			default: next_state = FETCH;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state <= FETCH;
		else
			state <= next_state;
	end

	// Instruction flags held until the next DECODE has used them
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			load_reg <= 1'b0;
			load_only <= 1'b0;
			store <= 1'b0;
			adc_sbc <= 1'b0;
			compare <= 1'b0;
			clc <= 1'b0;
			sec <= 1'b0;
			src <= ACC_A;
			dst <= ACC_A;
			op <= ALU_PASS_A;
		end else if (state == DECODE) begin
			load_reg <= (is_alu && ir.fld.aaa != AAA_STA && ir.fld.aaa != AAA_CMP) || is_xfer;
			load_only <= is_alu && ir.fld.aaa == AAA_LDA;
			store <= is_abs && ir.fld.aaa == AAA_STA;
			adc_sbc <= is_alu && ir.fld.aaa[1:0] == 2'b11; // ADC, SBC
			compare <= is_alu && ir.fld.aaa == AAA_CMP;
			clc <= valid && {ir.raw.acc, ir.raw.op} == {ACC_A, OP_CLC};
			sec <= valid && {ir.raw.acc, ir.raw.op} == {ACC_A, OP_SEC};
			src <= is_xfer ? acc_sel_t'(ir.raw.op[5:4]) : ir.raw.acc;
			dst <= ir.raw.acc;
			op <= dec_op;
		end
	end

	always_comb begin
		ctrl.ai_sel = AI_ZERO; // Default passes di through the adder
		ctrl.bi_sel = BI_DI;
		ctrl.ci_sel = CI_ZERO;
		ctrl.alu_op = ALU_ADD;
		ctrl.carry_op = C_HOLD;
		ctrl.rd_sel = src;
		ctrl.wr_sel = dst;
		ctrl.wr_en = 1'b0;
		ctrl.ab_sel = AB_PC;
		ctrl.pc_load = 1'b0;
		ctrl.pc_inc = 1'b1;
		we = 1'b0;
		case (state)
			DECODE: begin
				ctrl.wr_en = load_reg; // Result of previous instruction
				if (adc_sbc || compare)
					ctrl.carry_op = C_ALU;
				else if (sec)
					ctrl.carry_op = C_SET;
				else if (clc)
					ctrl.carry_op = C_CLEAR;
			end
			FETCH: begin
				ctrl.ai_sel = load_only ? AI_ZERO : AI_ACC;
				ctrl.ci_sel = compare ? CI_ONE : (load_only ? CI_ZERO : CI_FLAG);
				ctrl.alu_op = op;
			end
			REG: begin
				ctrl.ai_sel = AI_ACC;
				ctrl.bi_sel = BI_ZERO;
				ctrl.alu_op = op;
				ctrl.pc_inc = 1'b0; // Refetch the next opcode
			end
			ABS1: begin
				ctrl.ab_sel = AB_OPER;
				ctrl.pc_inc = 1'b0;
				we = store;
			end
			JMP1: begin
				ctrl.ab_sel = AB_OPER; // Fetch at target while PC goes past it
				ctrl.pc_load = 1'b1;
			end
			default: ; // ABS0, JMP0 latch the low address word
		endcase
	end

endmodule

`default_nettype wire

/* opc16_core.f */
design/cpu_pkg.sv
design/dp_ctrl_if.sv
design/alu.sv
design/acc_file.sv
design/addr_gen.sv
design/sequencer.sv
design/opc16_core.sv
testbench/tb_opc16_core.sv

/* testbench/program_input.mem */
// Words 00-7F: program and data image in hex, one or two instructions per line
// Word 80: expected write count, then one write per line: address high, address low, data
@00
00A9 1111 01A9 2222 02A9 3333 03A9 4444       // LDA #imm into A, B, C, D
008D 0070 0000 018D 0071 0000                 // STA A, STA B
028D 0072 0001 038D 0073 0000                 // STA C with high word 0001, STA D
01AD 0069 0000 0018                           // LDA B abs, CLC
016D 006A 0000 018D 0074 0000                 // ADC B abs sets carry, STA B
02A9 0000 0269 0000 028D 0075 0000            // C = 0 plus carry, STA C
0038 01E9 0300 018D 0076 0000                 // SEC, SBC B #0300 borrows, STA B
01ED 006C 0000 018D 0077 0000                 // SBC B abs with carry clear
0329 0F0F 0309 3000 0349 FFFF                 // AND, ORA, EOR immediate on D
038D 0078 0001                                // STA D with high word 0001
032D 006A 0000 030D 006C 0000 034D 006B 0000  // AND, ORA, EOR absolute on D
038D 0079 0000
00C9 2222 0069 0000 008D 007A 0000            // CMP A below operand, ADC #0, STA
00CD 006D 0000 0069 0000 008D 007B 0000       // CMP A above operand, ADC #0, STA
038B 00AB                                     // D from A, then A from C
038D 007C 0000 008D 007D 0000                 // STA D, STA A
004C 0063 0000                                // JMP over the next store
018D 007E 0000                                // skipped
018D 007F 0000                                // jump target
004C 0066 0000                                // park
@69
1234 F00F 8001 0FF0 00FF                      // operands at 69 to 6D
@80
000F
0000 0070 1111
0000 0071 2222
0001 0072 3333
0000 0073 4444
0000 0074 0243
0000 0075 0001
0000 0076 FF43
0000 0077 EF52
0001 0078 CBFB
0000 0079 4FFA
0000 007A 1111
0000 007B 1112
0000 007C 1112
0000 007D 0001
0000 007F EF52

/* testbench/tb_opc16_core.sv */
//------------------------------
// Testbench for opc16_core, run from the project root
// Program, data and expected writes come from program_input.mem
// Memory model is 128 words, indexed by ab[6:0]
// Expected write list holds at most 42 entries
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_opc16_core import cpu_pkg::*; ();

	localparam int RAM_WORDS = 128; // Program and data image
	localparam int EXP_BASE = 128; // Write count, then triples
	localparam int MAX_CYCLES = 4 * RAM_WORDS + 64;

	logic clk;
	logic reset;
	addr_t ab;
	word_t di = '0;
	word_t dout;
	logic we;

	word_t image [256]; // Memory in the low half, write list above
	addr_t exp_addr [$];
	word_t exp_data [$];
	int exp_count;
	int writes_seen = 0;
	int cycles = 0;
	addr_t rd_addr = '0; // ab at the last rising edge

	opc16_core #(.reset_pc('0)) i_opc16_core (
		.clk(clk),
		.reset(reset),
		.ab(ab),
		.di(di),
		.dout(dout),
		.we(we)
	);

	task automatic stop_on_error();
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input int idx);
		if (got !== exp) begin
			$display("mismatch at time %0t: write %0d went to address %h, expected %h",
				$time, idx, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_data(input word_t got, input word_t exp, input int idx);
		if (got !== exp) begin
			$display("mismatch at time %0t: write %0d carried data %h, expected %h",
				$time, idx, got, exp);
			stop_on_error();
		end
	endtask

	task automatic load_image();
		int n;
		logic [7:0] pos;
		$readmemh("testbench/program_input.mem", image);
		pos = 8'(EXP_BASE);
		exp_count = int'(image[pos]);
		if (exp_count == 0 || exp_count > (255 - EXP_BASE) / 3) begin
			$display("program_input.mem holds no usable count of expected writes");
			stop_on_error();
		end
		for (n = 0; n < exp_count; n++) begin
			exp_addr.push_back({image[pos + 8'd1], image[pos + 8'd2]}); // High word first
			exp_data.push_back(image[pos + 8'd3]);
			pos = pos + 8'd3;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// Synchronous memory, write checked against the list in order
	always @(posedge clk) begin
		rd_addr <= ab;
		if (we) begin
			if (writes_seen >= exp_count) begin
				$display("write %0d to address %h was not expected, only %0d writes are listed",
					writes_seen, ab, exp_count);
				stop_on_error();
			end else begin
				check_addr(ab, exp_addr[writes_seen], writes_seen);
				check_data(dout, exp_data[writes_seen], writes_seen);
				image[{1'b0, ab[6:0]}] <= dout; // Upper address bits alias
				writes_seen <= writes_seen + 1;
			end
		end
	end

	always @(negedge clk) begin
		di <= image[{1'b0, rd_addr[6:0]}]; // Data one cycle after the address
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("timeout after %0d cycles with %0d of %0d writes seen",
				cycles, writes_seen, exp_count);
			stop_on_error();
		end
	end

	initial begin
		reset = 1'b1;
		load_image();
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		wait (writes_seen == exp_count);
		repeat (16) @(posedge clk); // Any stray write after the last one fails
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
